// File: cartridge.f
+incdir+hdl
hdl/cart_pkg.sv
hdl/cart_bank_table.sv
hdl/cart_mapper_regs.sv
hdl/cart_addr_map.sv
hdl/cartridge.sv
tb/cartridge_tb.sv

// File: hdl/cart_addr_map.sv
// Cartridge address map
// Translates CPU accesses into SDRAM addresses of the loaded ROM and RAM banks
`timescale 1ns/1ps
`default_nettype none
`include "cart_cfg.svh"

module cart_addr_map (
	input  logic                    reset_n,
	input  cart_pkg::cpu_bus_t      bus,
	input  cart_pkg::bank_map_t     map,
	output logic [`CART_ADDR_W-1:0] addr_out,
	output logic                    mem_write_out,
	output logic                    mem_ce_out,
	output logic                    io_rom
);
	localparam int PAGE_W = `CART_ADDR_W - `CART_PAGE_LSB;

	logic              cs_ioe;
	logic              cs_iof;
	logic [PAGE_W-1:0] ioe_page;
	logic [PAGE_W-1:0] iof_page;
	logic [PAGE_W-1:0] win_page;

	// 8 KB page of a bank in the RAM or the ROM region
	function automatic logic [PAGE_W-1:0] bank_page(input logic [`CART_BANK_W-1:0] bank,
		input logic ram);
		logic [PAGE_W-1:0] page;
		page = '0;
		if (ram) begin
			page = PAGE_W'({`CART_RAM_PREFIX, bank[2:0]});
		end else begin
			page[`CART_ROM_BASE_BIT - `CART_PAGE_LSB] = 1'b1;
			page[`CART_BANK_W-1:0] = bank;
		end
		return page;
	endfunction

	// Window selected when enabled for this direction
	assign cs_ioe = bus.ioe && (bus.write ? map.ioe_wr_ena : map.ioe_ena);
	assign cs_iof = bus.iof && (bus.write ? map.iof_wr_ena : map.iof_ena);

	assign ioe_page = bank_page(map.ioe_bank, map.ioe_wr_ena);
	assign iof_page = bank_page(map.iof_bank, map.iof_wr_ena);
	assign win_page = cs_iof ? iof_page : ioe_page;

	// No RAM under the cartridge in ultimax
	assign mem_write_out = bus.write && !(bus.rom_l && map.exrom && !map.game);
	assign mem_ce_out    = bus.ce || cs_ioe || cs_iof;
	assign io_rom        = !bus.write && ((bus.ioe && map.ioe_ena) || (bus.iof && map.iof_ena));

	always_comb begin
		addr_out = {{(`CART_ADDR_W-16){1'b0}}, bus.addr};
		if (!reset_n) begin
			if (bus.rom_h && !bus.write)
				addr_out[`CART_ADDR_W-1:`CART_PAGE_LSB] = bank_page(map.bank_hi, 1'b0);
			if (bus.rom_l && !bus.write)
				addr_out[`CART_ADDR_W-1:`CART_PAGE_LSB] = bank_page(map.bank_lo, 1'b0);
			if (cs_ioe)
				addr_out[`CART_ADDR_W-1:`CART_PAGE_LSB] = ioe_page;  // $DExx
			if (cs_iof)
				addr_out[`CART_ADDR_W-1:`CART_PAGE_LSB] = iof_page;  // $DFxx
			// Upper 4 KB of ROMH for the VIC character fetch
			if (bus.umax_rom_h)
				addr_out[`CART_ADDR_W-1:`CART_PAGE_LSB-1] = {bank_page(map.bank_hi, 1'b0), 1'b1};
		end
	end

	// Active window always points at a defined page
	always_comb begin
		if (!reset_n && (cs_ioe || cs_iof))
			a_window_in_range: assert (!$isunknown(win_page));
	end

endmodule

`default_nettype wire

// File: hdl/cart_bank_table.sv
// Bank table for the loaded CRT image
// Records the SDRAM bank of every chip packet and counts the packets
`timescale 1ns/1ps
`default_nettype none
`include "cart_cfg.svh"

module cart_bank_table (
	input  logic                    clk32,
	input  logic                    reset_n,
	input  cart_pkg::cart_load_t    load,
	input  logic [`CART_IDX_W-1:0]  rd_index,
	output logic [`CART_BANK_W-1:0] lo_bank,
	output logic [`CART_BANK_W-1:0] hi_bank,
	output logic [7:0]              bank_count
);
	logic [`CART_BANK_W-1:0] lo_banks [`CART_SLOTS];   // $8000 halves
	logic [`CART_BANK_W-1:0] hi_banks [`CART_SLOTS];   // $A000/$E000 halves
	logic                    loading_q;
	logic                    load_start;
	logic [`CART_IDX_W-1:0]  slot;
	logic [`CART_BANK_W-1:0] rbank;

	assign slot       = load.bank_num[`CART_IDX_W-1:0];
	assign rbank      = load.raddr[`CART_PAGE_LSB +: `CART_BANK_W];
	assign load_start = load.loading && !loading_q;

	always_ff @(posedge clk32) begin
		if (load.wr && (load.bank_num < 16'(`CART_SLOTS))) begin
			if (load.laddr <= 16'h8000) begin
				lo_banks[slot] <= rbank;
				// 16 KB packet spills into the next bank
				if (load.size > 16'h2000)
					hi_banks[slot] <= rbank + 1'b1;
			end else begin
				hi_banks[slot] <= rbank;
			end
		end
	end

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			loading_q  <= 1'b0;
			bank_count <= '0;
		end else begin
			loading_q <= load.loading;
			if (load_start)
				bank_count <= load.wr ? 8'd1 : 8'd0;   // New image
			else if (load.wr)
				bank_count <= bank_count + 8'd1;
		end
	end

	assign lo_bank = lo_banks[rd_index];
	assign hi_bank = hi_banks[rd_index];

	a_rd_index_in_table: assert property (@(posedge clk32) disable iff (reset_n)
		!$isunknown(rd_index));

endmodule

`default_nettype wire

// File: hdl/cart_cfg.svh
// Cartridge mapper configuration
// Widths, bank table size, SDRAM region layout and cartridge type codes
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// *********************************************************************
// Widths and table size
// *********************************************************************
`define CART_ADDR_W        23       // SDRAM address
`define CART_BANK_W        7        // 8 KB bank number
`define CART_SLOTS         64       // Chip packet entries per table
`define CART_IDX_W         6        // Index into the bank table

// *********************************************************************
// SDRAM layout in 8 KB pages
// *********************************************************************
`define CART_PAGE_LSB      13
`define CART_ROM_BASE_BIT  20       // ROM banks from 0x100000, 1 MB
`define CART_RAM_PREFIX    7'h01    // RAM banks from 0x010000, 64 KB

// Cartridge type codes from the CRT header
`define CART_ID_GENERIC    16'd0
`define CART_ID_SIMONS     16'd4
`define CART_ID_OCEAN      16'd5
`define CART_ID_MAGIC_DESK 16'd19
`define CART_ID_EASYFLASH  16'd32
`define CART_ID_XBANK      16'd33

`endif

// File: hdl/cart_mapper_regs.sv
// Cartridge mapper registers
// Tracks I/O accesses per cartridge type and keeps banks, windows and lines
`timescale 1ns/1ps
`default_nettype none
`include "cart_cfg.svh"

module cart_mapper_regs (
	input  logic                    clk32,
	input  logic                    reset_n,
	input  logic [15:0]             cart_id,
	input  logic                    cart_exrom,  // CRT header EXROM
	input  logic                    cart_game,   // CRT header GAME
	input  cart_pkg::cart_load_t    load,
	input  cart_pkg::cpu_bus_t      bus,
	input  logic [`CART_BANK_W-1:0] lo_bank,
	input  logic [`CART_BANK_W-1:0] hi_bank,
	input  logic [7:0]              bank_count,
	output logic [`CART_IDX_W-1:0]  rd_index,
	output cart_pkg::bank_map_t     map
);
	logic                    ioe_q;
	logic                    iof_q;
	logic [15:0]             id_q;
	logic                    init_n;     // Low for the one init cycle
	logic                    stb_ioe;
	logic                    stb_iof;
	logic                    ioe_wr;
	logic                    ioe_rd;
	logic                    id_change;
	logic                    is_ef;
	logic [`CART_BANK_W-1:0] md_bank;

	// *********************************************************************
	// Strobes and type change
	// *********************************************************************
	always_ff @(posedge clk32) begin
		ioe_q <= bus.ioe;
		iof_q <= bus.iof;
		id_q  <= cart_id;
	end

	assign stb_ioe   = bus.ioe && !ioe_q;
	assign stb_iof   = bus.iof && !iof_q;
	assign ioe_wr    = stb_ioe && bus.write;
	assign ioe_rd    = stb_ioe && !bus.write;
	assign id_change = (id_q != cart_id);

	assign is_ef = (cart_id == `CART_ID_EASYFLASH) || (cart_id == `CART_ID_XBANK);

	// EasyFlash looks its banks up by the value written to $DE00
	assign rd_index = (is_ef && ioe_wr) ? bus.data[`CART_IDX_W-1:0] : '0;

	// Magic Desk bank bits follow the image size
	always_comb begin
		if (bank_count <= 8'd16)
			md_bank = {3'b000, bus.data[3:0]};
		else if (bank_count <= 8'd32)
			md_bank = {2'b00, bus.data[4:0]};
		else if (bank_count <= 8'd64)
			md_bank = {1'b0, bus.data[5:0]};
		else
			md_bank = bus.data[6:0];
	end

	// *********************************************************************
	// Per type register state
	// *********************************************************************
	always_ff @(posedge clk32) begin
		init_n <= 1'b1;
		if (reset_n || id_change) begin
			init_n    <= 1'b0;
			map       <= '0;
			map.exrom <= 1'b1;   // Cartridge off the bus
			map.game  <= 1'b1;
		end else begin
			case (cart_id)
				`CART_ID_GENERIC: begin
					map.exrom   <= cart_exrom;
					map.game    <= cart_game;
					map.bank_lo <= lo_bank;
					map.bank_hi <= hi_bank;
				end

				// Write to IOE gives 16K, read gives 8K
				`CART_ID_SIMONS: begin
					if (!init_n) begin
						map.exrom   <= 1'b0;
						map.game    <= 1'b0;
						map.bank_lo <= 7'd0;
						map.bank_hi <= 7'd1;
					end
					if (ioe_wr)
						map.game <= 1'b0;
					if (ioe_rd)
						map.game <= 1'b1;
				end

				`CART_ID_OCEAN: begin
					if (!init_n) begin
						map.exrom <= 1'b0;
						map.game  <= 1'b0;
					end
					if (ioe_wr) begin
						map.bank_lo <= {1'b0, bus.data[5:0]};  // Same bank at both halves
						map.bank_hi <= {1'b0, bus.data[5:0]};
					end
					// 512 KB images use only $8000, $A000 stays RAM
					if (load.wr && (load.bank_num >= 16'd32))
						map.game <= 1'b1;
				end

				`CART_ID_MAGIC_DESK: begin
					if (!init_n) begin
						map.exrom   <= 1'b0;
						map.game    <= 1'b1;
						map.bank_lo <= '0;
					end
					if (ioe_wr) begin
						map.bank_lo <= md_bank;
						map.exrom   <= bus.data[7];   // Bit 7 switches the cartridge off
					end
				end

				// EasyFlash boots in ultimax, XBank in 16K
				`CART_ID_EASYFLASH, `CART_ID_XBANK: begin
					if (!init_n) begin
						map.iof_bank   <= '0;
						map.iof_ena    <= 1'b1;
						map.iof_wr_ena <= 1'b1;  // 256 bytes of RAM at $DF00
						map.exrom      <= (cart_id == `CART_ID_EASYFLASH);
						map.game       <= 1'b0;
						map.bank_lo    <= lo_bank;
						map.bank_hi    <= hi_bank;
					end
					if (ioe_wr) begin
						if (bus.addr[1]) begin
							// Bit 2 low means the boot jumper decides
							map.game  <= !bus.data[0] && bus.data[2];
							map.exrom <= !bus.data[1];
						end else begin
							map.bank_lo <= lo_bank;
							map.bank_hi <= hi_bank;
						end
					end
				end

				default: begin
				end
			endcase
		end
	end

	a_lines_known: assert property (@(posedge clk32) disable iff (reset_n)
		!$isunknown({map.exrom, map.game}));

	a_strobes_apart: assert property (@(posedge clk32) disable iff (reset_n)
		!(stb_ioe && stb_iof));

endmodule

`default_nettype wire

// File: hdl/cart_pkg.sv
// Cartridge mapper types
// Load records, CPU side bus and the mapping state passed between blocks
`default_nettype none
`include "cart_cfg.svh"

package cart_pkg;

	// One chip packet record from the CRT loader
	typedef struct packed {
		logic                    loading;   // Level, high for the whole load
		logic                    wr;        // One cycle per record
		logic [15:0]             bank_num;
		logic [15:0]             laddr;     // C64 load address of the packet
		logic [15:0]             size;
		logic [`CART_ADDR_W-1:0] raddr;     // Where the packet sits in SDRAM
	} cart_load_t;

	// CPU access as seen by the cartridge port
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;
		logic        ce;
		logic        rom_l;
		logic        rom_h;
		logic        umax_rom_h;  // VIC fetch from ROMH in ultimax
		logic        ioe;
		logic        iof;
	} cpu_bus_t;

	// Current banking and the cartridge lines
	typedef struct packed {
		logic [`CART_BANK_W-1:0] bank_lo;
		logic [`CART_BANK_W-1:0] bank_hi;
		logic [`CART_BANK_W-1:0] ioe_bank;
		logic [`CART_BANK_W-1:0] iof_bank;
		logic                    ioe_ena;
		logic                    iof_ena;
		logic                    ioe_wr_ena;  // Window holds RAM
		logic                    iof_wr_ena;
		logic                    exrom;
		logic                    game;
	} bank_map_t;

endpackage

`default_nettype wire

// File: hdl/cartridge.sv
// CRT cartridge handler
// Bank table, mapper registers and SDRAM address map of the C64 expansion port
`timescale 1ns/1ps
`default_nettype none
`include "cart_cfg.svh"

module cartridge (
	input  logic                    clk32,
	input  logic                    reset_n,
	input  logic                    cart_loading,
	input  logic [15:0]             cart_id,
	input  logic [7:0]              cart_exrom,       // CRT status, bit 0 used
	input  logic [7:0]              cart_game,
	input  logic [15:0]             cart_bank_laddr,
	input  logic [15:0]             cart_bank_size,
	input  logic [15:0]             cart_bank_num,
	input  logic [`CART_ADDR_W-1:0] cart_bank_raddr,
	input  logic                    cart_bank_wr,
	input  logic                    rom_l,
	input  logic                    rom_h,
	input  logic                    umax_rom_h,
	input  logic                    ioe,
	input  logic                    iof,
	input  logic                    mem_write,
	input  logic                    mem_ce,
	input  logic [15:0]             addr_in,
	input  logic [7:0]              data_in,
	output logic                    exrom,
	output logic                    game,
	output logic                    mem_ce_out,
	output logic                    mem_write_out,
	output logic                    io_rom,
	output logic [`CART_ADDR_W-1:0] addr_out
);
	cart_pkg::cart_load_t    load;
	cart_pkg::cpu_bus_t      bus;
	cart_pkg::bank_map_t     map;
	logic [`CART_IDX_W-1:0]  rd_index;
	logic [`CART_BANK_W-1:0] lo_bank;
	logic [`CART_BANK_W-1:0] hi_bank;
	logic [7:0]              bank_count;

	// *********************************************************************
	// Port bundling
	// *********************************************************************
	assign load = '{loading: cart_loading, wr: cart_bank_wr, bank_num: cart_bank_num,
		laddr: cart_bank_laddr, size: cart_bank_size, raddr: cart_bank_raddr};

	assign bus = '{addr: addr_in, data: data_in, write: mem_write, ce: mem_ce,
		rom_l: rom_l, rom_h: rom_h, umax_rom_h: umax_rom_h, ioe: ioe, iof: iof};

	assign exrom = map.exrom;
	assign game  = map.game;

	cart_bank_table i_bank_table (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.load       (load),
		.rd_index   (rd_index),
		.lo_bank    (lo_bank),
		.hi_bank    (hi_bank),
		.bank_count (bank_count)
	);

	cart_mapper_regs i_mapper_regs (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom[0]),
		.cart_game  (cart_game[0]),
		.load       (load),
		.bus        (bus),
		.lo_bank    (lo_bank),
		.hi_bank    (hi_bank),
		.bank_count (bank_count),
		.rd_index   (rd_index),
		.map        (map)
	);

	cart_addr_map i_addr_map (
		.reset_n       (reset_n),
		.bus           (bus),
		.map           (map),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.mem_ce_out    (mem_ce_out),
		.io_rom        (io_rom)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the cartridge testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f cartridge.f --top-module cartridge_tb \
	-Mdir obj_dir -o cartridge_sim &&
./obj_dir/cartridge_sim > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/cartridge_tb.sv
// Testbench for the cartridge handler
// Applies a table of load, I/O and probe accesses and checks lines and SDRAM addresses
`timescale 1ns/1ps
`default_nettype none

module cartridge_tb;

	typedef struct {
		string       name;
		logic [15:0] id;
		int          load_n;      // Records to load, 0 for none
		logic [15:0] bank_num;
		logic [22:0] raddr;
		bit          io;          // IOE access before the probe
		bit          io_wr;
		logic [15:0] io_addr;
		logic [7:0]  io_data;
		int          probe;       // 0 rom_l, 1 rom_h, 2 iof
		bit          probe_wr;
		logic [22:0] exp_page;
		bit          exp_exrom;
		bit          exp_game;
		bit          exp_ce;
		bit          exp_we;
		bit          exp_io;      // ROM data driven onto the I/O area
	} row_t;

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	logic [15:0] cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	logic [22:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        rom_l, rom_h, umax_rom_h, ioe, iof;
	logic        mem_write, mem_ce;
	logic [15:0] addr_in;
	logic [7:0]  data_in;
	logic        exrom, game, mem_ce_out, mem_write_out, io_rom;
	logic [22:0] addr_out;

	row_t        rows[$];
	integer      seed = 32'h6771_2821;
	int          error_count = 0;
	int          cycles = 0;
	int          cycle_limit = 32'h7FFF_FFFF;

	cartridge i_dut (.*);

	initial begin
		clk32 = 1'b0;
		forever #5 clk32 = ~clk32;
	end

	// Run length guard
	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: simulation ran past %0d cycles", cycle_limit);
			$display("Checks failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic add_row(input string name, input logic [15:0] id, input int load_n,
		input logic [15:0] bank_num, input logic [22:0] raddr, input bit io, input bit io_wr,
		input logic [15:0] io_addr, input logic [7:0] io_data, input int probe,
		input bit probe_wr, input logic [22:0] exp_page, input bit exp_exrom,
		input bit exp_game, input bit exp_ce, input bit exp_we, input bit exp_io);
		row_t r;
		r = '{name, id, load_n, bank_num, raddr, io, io_wr, io_addr, io_data, probe,
			probe_wr, exp_page, exp_exrom, exp_game, exp_ce, exp_we, exp_io};
		rows.push_back(r);
	endtask

	// ROM banks from 0x100000, RAM banks from 0x010000, all 8 KB pages
	function automatic logic [22:0] rom_page(input int bank);
		return 23'h100000 + 23'(bank) * 23'h2000;
	endfunction

	function automatic logic [22:0] ram_page(input int bank);
		return 23'h010000 + 23'(bank % 8) * 23'h2000;
	endfunction

	task automatic load_records(input row_t r);
		@(negedge clk32) cart_loading = 1'b1;
		for (int i = 0; i < r.load_n; i++) begin
			@(negedge clk32);
			cart_bank_wr    = 1'b1;
			cart_bank_num   = r.bank_num + 16'(i);
			cart_bank_raddr = r.raddr + 23'(i) * 23'h2000;
			cart_bank_laddr = 16'h8000;
			cart_bank_size  = (r.load_n == 1) ? 16'h4000 : 16'h2000;
		end
		@(negedge clk32);
		cart_bank_wr = 1'b0;
		cart_loading = 1'b0;
	endtask

	task automatic io_access(input row_t r);
		@(negedge clk32);
		ioe       = 1'b1;
		mem_write = r.io_wr;
		addr_in   = r.io_addr;
		data_in   = r.io_data;
		@(negedge clk32);
		ioe       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic probe_access(input row_t r);
		logic [31:0] rnd;
		logic [22:0] expected;
		rnd = $random(seed);
		@(negedge clk32);
		mem_write = r.probe_wr;
		case (r.probe)
			0: begin
				rom_l   = 1'b1;
				addr_in = {3'b100, rnd[12:0]};
			end
			1: begin
				rom_h   = 1'b1;
				addr_in = {3'b101, rnd[12:0]};
			end
			default: begin
				iof     = 1'b1;
				addr_in = {8'hDF, rnd[7:0]};
			end
		endcase
		expected = r.exp_page + {10'd0, addr_in[12:0]};   // Offset bits pass through
		#2;
		check({r.name, " addr_out"}, {9'd0, expected}, {9'd0, addr_out});
		check({r.name, " exrom"}, {31'd0, r.exp_exrom}, {31'd0, exrom});
		check({r.name, " game"}, {31'd0, r.exp_game}, {31'd0, game});
		check({r.name, " mem_ce_out"}, {31'd0, r.exp_ce}, {31'd0, mem_ce_out});
		check({r.name, " mem_write_out"}, {31'd0, r.exp_we}, {31'd0, mem_write_out});
		check({r.name, " io_rom"}, {31'd0, r.exp_io}, {31'd0, io_rom});
		@(negedge clk32);
		{rom_l, rom_h, iof, mem_write} = 4'b0000;
	endtask

	// **********************************************************************
	// Main sequence
	// **********************************************************************
	initial begin
		reset_n = 1'b1;
		cart_loading = 1'b0;
		cart_id = 16'd0;
		cart_exrom = 8'h00;   // Generic image with EXROM 0, GAME 1
		cart_game = 8'h01;
		cart_bank_laddr = 16'h0;
		cart_bank_size = 16'h0;
		cart_bank_num = 16'h0;
		cart_bank_raddr = 23'h0;
		cart_bank_wr = 1'b0;
		{rom_l, rom_h, umax_rom_h, ioe, iof, mem_write, mem_ce} = 7'b0;
		addr_in = 16'h0;
		data_in = 8'h0;

		// Name, id, records, bank_num, raddr, io, io_wr, io_addr, io_data
		// then probe, probe_wr, page, exrom, game, ce, we, io_rom
		add_row("generic_rom_l", 16'd0, 1, 16'd0, 23'h004000, 0, 0, 16'h0, 8'h0,
			0, 0, rom_page(2), 0, 1, 0, 0, 0);
		add_row("generic_rom_h", 16'd0, 0, 16'd0, 23'h0, 0, 0, 16'h0, 8'h0,
			1, 0, rom_page(3), 0, 1, 0, 0, 0);
		add_row("ocean_bank", 16'd5, 0, 16'd0, 23'h0, 1, 1, 16'hDE00, 8'h05,
			1, 0, rom_page(5), 0, 0, 0, 0, 0);
		add_row("ocean_512k", 16'd5, 1, 16'd40, 23'h050000, 0, 0, 16'h0, 8'h0,
			0, 0, rom_page(5), 0, 1, 0, 0, 0);
		add_row("magic_desk_bank", 16'd19, 20, 16'd0, 23'h100000, 1, 1, 16'hDE00, 8'h3F,
			0, 0, rom_page(31), 0, 1, 0, 0, 0);
		add_row("magic_desk_off", 16'd19, 0, 16'd0, 23'h0, 1, 1, 16'hDE00, 8'h80,
			0, 0, rom_page(0), 1, 1, 0, 0, 0);
		add_row("ef_init", 16'd32, 0, 16'd0, 23'h0, 0, 0, 16'h0, 8'h0,
			2, 0, ram_page(0), 1, 0, 1, 0, 1);
		add_row("ef_ultimax_wr", 16'd32, 0, 16'd0, 23'h0, 0, 0, 16'h0, 8'h0,
			0, 1, 23'h008000, 1, 0, 0, 0, 0);
		add_row("ef_control", 16'd32, 0, 16'd0, 23'h0, 1, 1, 16'hDE02, 8'h06,
			2, 0, ram_page(0), 0, 1, 1, 0, 1);
		add_row("ef_bank", 16'd32, 1, 16'd3, 23'h0A6000, 1, 1, 16'hDE00, 8'h03,
			0, 0, rom_page(8'h53), 0, 1, 0, 0, 0);
		add_row("ef_ram_wr", 16'd32, 0, 16'd0, 23'h0, 0, 0, 16'h0, 8'h0,
			2, 1, ram_page(0), 0, 1, 1, 1, 0);
		add_row("simons_read", 16'd4, 0, 16'd0, 23'h0, 1, 0, 16'hDE00, 8'h0,
			1, 0, rom_page(1), 0, 1, 0, 0, 0);
		add_row("simons_write", 16'd4, 0, 16'd0, 23'h0, 1, 1, 16'hDE00, 8'h0,
			0, 0, rom_page(0), 0, 0, 0, 0, 0);
		add_row("xbank_init", 16'd33, 0, 16'd0, 23'h0, 0, 0, 16'h0, 8'h0,
			2, 0, ram_page(0), 0, 0, 1, 0, 1);
		cycle_limit = 10 + 40 * rows.size();

		repeat (10) @(negedge clk32);
		reset_n = 1'b0;
		#1;
		check("reset exrom", 32'd1, {31'd0, exrom});
		check("reset game", 32'd1, {31'd0, game});

		foreach (rows[i]) begin
			if (rows[i].id != cart_id) begin
				cart_id = rows[i].id;
				// Lines sit at their reset value until the new type's init
				@(negedge clk32);
				#1;
				check({rows[i].name, " id change exrom"}, 32'd1, {31'd0, exrom});
				check({rows[i].name, " id change game"}, 32'd1, {31'd0, game});
			end
			repeat (3) @(negedge clk32);
			if (rows[i].load_n > 0)
				load_records(rows[i]);
			if (rows[i].io)
				io_access(rows[i]);
			probe_access(rows[i]);
		end

		if (error_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
